// File: Bender.yml
package:
  name: periph_bus

sources:
  - periph_bus_pkg.sv
  - apb_node.sv
  - apb_gpio.sv
  - apb_timer.sv
  - apb_soc_ctrl.sv
  - periph_bus_wrap.sv
  - target: test
    files:
      - tb_periph_bus.sv

// File: apb_gpio.sv
/*
 * APB GPIO block
 *   output and output-enable registers written over APB
 *   two-flop synchronizer on the input pins
 */
module apb_gpio
  import periph_bus_pkg::*;
#(
  parameter int unsigned nb_gpio = 8
) (
  input  logic               clk_i,
  input  logic               rst,
  input  apb_req_t           req,
  output apb_resp_t          resp,
  input  logic [nb_gpio-1:0] gpio_in,
  output logic [nb_gpio-1:0] gpio_out,
  output logic [nb_gpio-1:0] gpio_oe
);

  logic [11:0]        offs;
  logic               wr_en;
  logic [nb_gpio-1:0] in_meta;
  logic [nb_gpio-1:0] in_sync;

  assign offs  = req.paddr[11:0];
  assign wr_en = req.psel & req.penable & req.pwrite;

  // ****************************************
  // registers
  // ****************************************

  always_ff @(posedge clk_i) begin
    if (rst) begin
      gpio_out <= '0;
      gpio_oe  <= '0;
    end else if (wr_en) begin
      if (offs == gpio_out_offs) gpio_out <= req.pwdata[nb_gpio-1:0];
      if (offs == gpio_oe_offs) gpio_oe <= req.pwdata[nb_gpio-1:0];
    end
  end

  // pins are asynchronous to clk_i, the second flop is what software reads
  always_ff @(posedge clk_i) begin
    in_meta <= gpio_in;
    in_sync <= in_meta;
  end

  // zero-wait-state slave, upper bits and unknown offsets read as zero
  always_comb begin
    resp.prdata  = '0;
    resp.pready  = 1'b1;
    resp.pslverr = 1'b0;
    case (offs)
      gpio_out_offs: resp.prdata[nb_gpio-1:0] = gpio_out;
      gpio_oe_offs:  resp.prdata[nb_gpio-1:0] = gpio_oe;
      gpio_in_offs:  resp.prdata[nb_gpio-1:0] = in_sync;
      default:       resp.prdata = '0;
    endcase
  end

endmodule

// File: apb_node.sv
/*
 * APB node
 *   address decoder against the package memory map
 *   request demultiplexer and response multiplexer
 *   error response for unmapped addresses
 */
module apb_node
  import periph_bus_pkg::*;
(
  input  apb_req_t  mst_req,
  output apb_resp_t mst_resp,
  output apb_req_t  slv_req  [nb_slave],
  input  apb_resp_t slv_resp [nb_slave]
);

  // one bit per slave, at most one bit set since the windows do not overlap
  logic [nb_slave-1:0] sel;

  function automatic logic in_window(
    input logic [apb_addr_width-1:0] addr,
    input logic [apb_addr_width-1:0] start_addr,
    input logic [apb_addr_width-1:0] end_addr
  );
    return (addr >= start_addr) && (addr <= end_addr);
  endfunction

  // ****************************************
  // address decode
  // ****************************************

  always_comb begin
    sel = '0;
    sel[slave_idx_gpio] = in_window(mst_req.paddr, gpio_start_addr, gpio_end_addr);
    sel[slave_idx_timer] = in_window(mst_req.paddr, timer_start_addr, timer_end_addr);
    sel[slave_idx_soc_ctrl] = in_window(mst_req.paddr, soc_ctrl_start_addr,
                                        soc_ctrl_end_addr);
  end

  // ****************************************
  // request demultiplexer
  // ****************************************

  // address, write data and direction are shared by all slaves, only the
  // selected one sees psel and penable
  always_comb begin
    for (int i = 0; i < nb_slave; i++) begin
      slv_req[i]         = mst_req;
      slv_req[i].psel    = mst_req.psel & sel[i];
      slv_req[i].penable = mst_req.penable & sel[i];
    end
  end

  // ****************************************
  // response multiplexer
  // ****************************************

  // with no window hit the node answers on its own: ready at once, error
  // flagged and the read data forced to zero
  always_comb begin
    mst_resp.prdata  = '0;
    mst_resp.pready  = 1'b1;
    mst_resp.pslverr = 1'b1;
    for (int i = 0; i < nb_slave; i++) begin
      if (sel[i]) begin
        mst_resp = slv_resp[i];
      end
    end
  end

endmodule

// File: apb_soc_ctrl.sv
/*
 * APB system-control block
 *   read-only chip identifier, scratch word, boot-address register
 */
module apb_soc_ctrl
  import periph_bus_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst,
  input  apb_req_t                  req,
  output apb_resp_t                 resp,
  output logic [apb_data_width-1:0] boot_addr
);

  logic [11:0]               offs;
  logic                      wr_en;
  logic [apb_data_width-1:0] scratch_q;

  assign offs  = req.paddr[11:0];
  assign wr_en = req.psel & req.penable & req.pwrite;

  // ****************************************
  // registers
  // ****************************************

  always_ff @(posedge clk_i) begin
    if (rst) begin
      boot_addr <= boot_addr_rst;
    end else if (wr_en && offs == soc_boot_addr_offs) begin
      boot_addr <= req.pwdata;
    end
  end

  // software scratch word, its content after reset is undefined
  always_ff @(posedge clk_i) begin
    if (wr_en && offs == soc_scratch_offs) scratch_q <= req.pwdata;
  end

  // writes to the identifier offset are accepted and dropped
  always_comb begin
    resp.pready  = 1'b1;
    resp.pslverr = 1'b0;
    case (offs)
      soc_chip_id_offs:   resp.prdata = chip_id;
      soc_scratch_offs:   resp.prdata = scratch_q;
      soc_boot_addr_offs: resp.prdata = boot_addr;
      default:            resp.prdata = '0;
    endcase
  end

endmodule

// File: apb_timer.sv
/*
 * APB timer
 *   enable, compare and counter registers
 *   one-cycle event pulse at each compare match
 */
module apb_timer
  import periph_bus_pkg::*;
#(
  parameter int unsigned cnt_width = 16
) (
  input  logic      clk_i,
  input  logic      rst,
  input  apb_req_t  req,
  output apb_resp_t resp,
  output logic      timer_event
);

  logic [11:0]          offs;
  logic                 wr_en;
  logic                 enable;
  logic [cnt_width-1:0] cmp_q;
  logic [cnt_width-1:0] cnt_q;
  logic                 match;

  assign offs  = req.paddr[11:0];
  assign wr_en = req.psel & req.penable & req.pwrite;

  // a match only counts while the timer runs
  assign match = enable && (cnt_q == cmp_q);

  // ****************************************
  // counter and event
  // ****************************************

  // the counter wraps at the match edge, so one period is cmp_q+1 cycles
  // and timer_event is high for the cycle right after that edge
  always_ff @(posedge clk_i) begin
    if (rst) begin
      enable      <= 1'b0;
      cmp_q       <= '0;
      cnt_q       <= '0;
      timer_event <= 1'b0;
    end else begin
      timer_event <= match;
      if (wr_en && offs == timer_ctrl_offs) enable <= req.pwdata[0];
      if (wr_en && offs == timer_cmp_offs) begin
        cmp_q <= req.pwdata[cnt_width-1:0];
        cnt_q <= '0;
      end else if (match) begin
        cnt_q <= '0;
      end else if (enable) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  always_comb begin
    resp.prdata  = '0;
    resp.pready  = 1'b1;
    resp.pslverr = 1'b0;
    case (offs)
      timer_ctrl_offs: resp.prdata[0] = enable;
      timer_cmp_offs:  resp.prdata[cnt_width-1:0] = cmp_q;
      timer_cnt_offs:  resp.prdata[cnt_width-1:0] = cnt_q;
      default:         resp.prdata = '0;
    endcase
  end

endmodule

// File: periph_bus_pkg.sv
/*
 * Peripheral bus package
 *   APB request and response structs, bus widths
 *   memory map of the three peripheral windows
 *   register offsets, chip identifier and reset values
 */
package periph_bus_pkg;

  // ****************************************
  // bus widths and structs
  // ****************************************

  localparam int unsigned apb_addr_width = 32;
  localparam int unsigned apb_data_width = 32;

  // driven by the master side
  typedef struct packed {
    logic [apb_addr_width-1:0] paddr;
    logic [apb_data_width-1:0] pwdata;
    logic                      pwrite;
    logic                      psel;
    logic                      penable;
  } apb_req_t;

  // driven by the slave side
  typedef struct packed {
    logic [apb_data_width-1:0] prdata;
    logic                      pready;
    logic                      pslverr;
  } apb_resp_t;

  // ****************************************
  // memory map
  // ****************************************

  localparam int unsigned nb_slave = 3;

  // slot of each peripheral in the node's slave arrays
  localparam int unsigned slave_idx_gpio     = 0;
  localparam int unsigned slave_idx_timer    = 1;
  localparam int unsigned slave_idx_soc_ctrl = 2;

  localparam logic [apb_addr_width-1:0] gpio_start_addr     = 32'h1A10_1000;
  localparam logic [apb_addr_width-1:0] gpio_end_addr       = 32'h1A10_1FFF;
  localparam logic [apb_addr_width-1:0] timer_start_addr    = 32'h1A10_B000;
  localparam logic [apb_addr_width-1:0] timer_end_addr      = 32'h1A10_BFFF;
  localparam logic [apb_addr_width-1:0] soc_ctrl_start_addr = 32'h1A10_4000;
  localparam logic [apb_addr_width-1:0] soc_ctrl_end_addr   = 32'h1A10_4FFF;

  // register offsets inside a 4 KiB window, one word each
  localparam logic [11:0] gpio_out_offs      = 12'h000;
  localparam logic [11:0] gpio_oe_offs       = 12'h004;
  localparam logic [11:0] gpio_in_offs       = 12'h008;

  localparam logic [11:0] timer_ctrl_offs    = 12'h000;
  localparam logic [11:0] timer_cmp_offs     = 12'h004;
  localparam logic [11:0] timer_cnt_offs     = 12'h008;

  localparam logic [11:0] soc_chip_id_offs   = 12'h000;
  localparam logic [11:0] soc_scratch_offs   = 12'h004;
  localparam logic [11:0] soc_boot_addr_offs = 12'h008;

  // ****************************************
  // constants
  // ****************************************

  localparam logic [apb_data_width-1:0] chip_id       = 32'h5050_0001;
  localparam logic [apb_data_width-1:0] boot_addr_rst = 32'h1C00_8080;

endpackage

// File: periph_bus_wrap.sv
/*
 * Peripheral bus top level
 *   APB node plus GPIO, timer and system-control peripherals
 */
module periph_bus_wrap
  import periph_bus_pkg::*;
#(
  parameter int unsigned nb_gpio   = 8,
  parameter int unsigned cnt_width = 16
) (
  input  logic                      clk_i,
  input  logic                      rst,
  input  apb_req_t                  apb_req,
  output apb_resp_t                 apb_resp,
  input  logic [nb_gpio-1:0]        gpio_in,
  output logic [nb_gpio-1:0]        gpio_out,
  output logic [nb_gpio-1:0]        gpio_oe,
  output logic                      timer_event,
  output logic [apb_data_width-1:0] boot_addr
);

  apb_req_t  slv_req  [nb_slave];
  apb_resp_t slv_resp [nb_slave];

  // ****************************************
  // peripheral bus
  // ****************************************
  apb_node u_apb_node (
    .mst_req (apb_req),
    .mst_resp(apb_resp),
    .slv_req (slv_req),
    .slv_resp(slv_resp)
  );

  // each peripheral sits in the node slot given by the package index
  apb_gpio #(
    .nb_gpio(nb_gpio)
  ) u_apb_gpio (
    .clk_i   (clk_i),
    .rst     (rst),
    .req     (slv_req[slave_idx_gpio]),
    .resp    (slv_resp[slave_idx_gpio]),
    .gpio_in (gpio_in),
    .gpio_out(gpio_out),
    .gpio_oe (gpio_oe)
  );

  apb_timer #(
    .cnt_width(cnt_width)
  ) u_apb_timer (
    .clk_i      (clk_i),
    .rst        (rst),
    .req        (slv_req[slave_idx_timer]),
    .resp       (slv_resp[slave_idx_timer]),
    .timer_event(timer_event)
  );

  apb_soc_ctrl u_apb_soc_ctrl (
    .clk_i    (clk_i),
    .rst      (rst),
    .req      (slv_req[slave_idx_soc_ctrl]),
    .resp     (slv_resp[slave_idx_soc_ctrl]),
    .boot_addr(boot_addr)
  );

endmodule

// File: tb_periph_bus.sv
/*
 * Testbench for the peripheral bus subsystem
 *   APB read and write tasks, concurrent checks on pslverr and timer_event
 *   reset values, register read-back, GPIO pins, timer period, unmapped accesses
 */
module tb_periph_bus
  import periph_bus_pkg::*;
();

  localparam int unsigned nb_gpio     = 8;
  localparam int unsigned cnt_width   = 16;
  localparam int          apb_timeout = 16;

  logic                      clk_i;
  logic                      rst;
  apb_req_t                  apb_req;
  apb_resp_t                 apb_resp;
  logic [nb_gpio-1:0]        gpio_in;
  logic [nb_gpio-1:0]        gpio_out;
  logic [nb_gpio-1:0]        gpio_oe;
  logic                      timer_event;
  logic [apb_data_width-1:0] boot_addr;

  logic   exp_err;
  integer seed = 20;
  int     check_errors;
  int     assert_errors;

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  periph_bus_wrap #(
    .nb_gpio  (nb_gpio),
    .cnt_width(cnt_width)
  ) u_periph_bus_wrap (
    .clk_i      (clk_i),
    .rst        (rst),
    .apb_req    (apb_req),
    .apb_resp   (apb_resp),
    .gpio_in    (gpio_in),
    .gpio_out   (gpio_out),
    .gpio_oe    (gpio_oe),
    .timer_event(timer_event),
    .boot_addr  (boot_addr)
  );

  // ****************************************
  // concurrent checks
  // ****************************************

  // every completed transfer carries the error flag the test expects
  pslverr_check: assert property (@(posedge clk_i) disable iff (rst)
    (apb_req.psel && apb_req.penable && apb_resp.pready) |-> (apb_resp.pslverr == exp_err))
  else begin
    assert_errors++;
    $display("Mismatch at %0t: pslverr %b at address %h", $time, apb_resp.pslverr,
             apb_req.paddr);
  end

  event_pulse_check: assert property (@(posedge clk_i) disable iff (rst)
    timer_event |=> !timer_event)
  else begin
    assert_errors++;
    $display("Mismatch at %0t: timer_event high on two consecutive cycles", $time);
  end

  // ****************************************
  // tasks
  // ****************************************

  task automatic end_run();
    $display("errors: %0d procedural, %0d assertion", check_errors, assert_errors);
    if (check_errors == 0 && assert_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      check_errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // setup phase followed by the access phase until pready, which is sampled
  // at the falling edge
  task automatic apb_transfer(input logic [31:0] addr, input logic wr,
                              input logic [31:0] wdata, input logic err,
                              output logic [31:0] rdata);
    int waited;
    @(posedge clk_i);
    exp_err         <= err;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    apb_req.pwrite  <= wr;
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    @(posedge clk_i);
    apb_req.penable <= 1'b1;
    waited = 0;
    @(negedge clk_i);
    while (!apb_resp.pready && waited < apb_timeout) begin
      waited++;
      @(negedge clk_i);
    end
    if (!apb_resp.pready) begin
      check_errors++;
      $display("APB transfer to address %h never received pready", addr);
    end
    rdata = apb_resp.prdata;
    @(posedge clk_i);
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic err);
    logic [31:0] ignored;
    apb_transfer(addr, 1'b1, data, err, ignored);
  endtask

  task automatic apb_read(input logic [31:0] addr, input logic err,
                          output logic [31:0] data);
    apb_transfer(addr, 1'b0, '0, err, data);
  endtask

  // counts falling edges up to and including the next timer_event
  task automatic wait_event(input int limit, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk_i);
      cycles++;
    end while (!timer_event && cycles < limit);
    if (!timer_event) begin
      check_errors++;
      $display("timer_event did not arrive within %0d cycles", limit);
    end
  endtask

  // ****************************************
  // test sequence
  // ****************************************

  initial begin
    logic [31:0]        data;
    logic [31:0]        scratch_val;
    logic [31:0]        boot_val;
    logic [nb_gpio-1:0] out_val;
    logic [nb_gpio-1:0] oe_val;
    logic [nb_gpio-1:0] in_val;
    int                 n;
    int                 gap;
    int                 tries;
    check_errors  = 0;
    assert_errors = 0;
    exp_err       = 1'b0;
    rst           = 1'b1;
    apb_req       = '0;
    gpio_in       = '0;
    repeat (16) @(posedge clk_i);
    rst <= 1'b0;

    // reset values
    apb_read(soc_ctrl_start_addr + soc_chip_id_offs, 1'b0, data);
    check_value("chip_id", data, chip_id);
    @(negedge clk_i);
    check_value("boot_addr port", boot_addr, boot_addr_rst);
    check_value("gpio_out port", gpio_out, '0);
    check_value("gpio_oe port", gpio_oe, '0);

    // the identifier in the system-control block ignores writes
    scratch_val = $random(seed);
    boot_val    = $random(seed);
    apb_write(soc_ctrl_start_addr + soc_scratch_offs, scratch_val, 1'b0);
    apb_write(soc_ctrl_start_addr + soc_boot_addr_offs, boot_val, 1'b0);
    apb_write(soc_ctrl_start_addr + soc_chip_id_offs, $random(seed), 1'b0);
    apb_read(soc_ctrl_start_addr + soc_scratch_offs, 1'b0, data);
    check_value("scratch", data, scratch_val);
    apb_read(soc_ctrl_start_addr + soc_boot_addr_offs, 1'b0, data);
    check_value("boot address register", data, boot_val);
    apb_read(soc_ctrl_start_addr + soc_chip_id_offs, 1'b0, data);
    check_value("chip_id after write", data, chip_id);
    @(negedge clk_i);
    check_value("boot_addr port", boot_addr, boot_val);

    // GPIO outputs first and then the input pins through the synchronizer
    out_val = $random(seed);
    oe_val  = $random(seed);
    apb_write(gpio_start_addr + gpio_out_offs, out_val, 1'b0);
    apb_write(gpio_start_addr + gpio_oe_offs, oe_val, 1'b0);
    @(negedge clk_i);
    check_value("gpio_out port", gpio_out, out_val);
    check_value("gpio_oe port", gpio_oe, oe_val);
    @(posedge clk_i);
    in_val = $random(seed);
    gpio_in <= in_val;
    tries = 0;
    do begin
      apb_read(gpio_start_addr + gpio_in_offs, 1'b0, data);
      tries++;
    end while (data !== in_val && tries < 8);
    check_value("gpio_in register", data, in_val);

    // timer period is compare+1 cycles
    n = 2 + ({$random(seed)} % 8);
    apb_write(timer_start_addr + timer_cmp_offs, n, 1'b0);
    apb_write(timer_start_addr + timer_ctrl_offs, 32'h1, 1'b0);
    wait_event(4 * (n + 1), gap);
    for (int p = 0; p < 4; p++) begin
      wait_event(4 * (n + 1), gap);
      check_value("timer_event gap", gap, n + 1);
    end
    apb_write(timer_start_addr + timer_ctrl_offs, 32'h0, 1'b0);
    // a match at the disabling edge may still give one last pulse
    @(negedge clk_i);
    for (int c = 0; c < 4 * (n + 1); c++) begin
      @(negedge clk_i);
      if (timer_event) begin
        check_errors++;
        $display("Mismatch at %0t: timer_event pulsed after the timer was disabled",
                 $time);
      end
    end

    // unmapped addresses first and then the first and last word of each window
    apb_read(32'h1A10_2000, 1'b1, data);
    check_value("unmapped read data", data, '0);
    apb_write(32'h1A10_2000, $random(seed), 1'b1);
    apb_read(32'h0000_0000, 1'b1, data);
    check_value("unmapped read data", data, '0);
    apb_read(gpio_start_addr, 1'b0, data);
    check_value("gpio first word", data, out_val);
    apb_read(timer_start_addr, 1'b0, data);
    check_value("timer first word", data, '0);
    apb_read(soc_ctrl_start_addr, 1'b0, data);
    check_value("soc_ctrl first word", data, chip_id);
    apb_write(gpio_end_addr - 3, $random(seed), 1'b0);
    apb_write(timer_end_addr - 3, $random(seed), 1'b0);
    apb_write(soc_ctrl_end_addr - 3, $random(seed), 1'b0);
    apb_read(soc_ctrl_end_addr - 3, 1'b0, data);
    check_value("soc_ctrl last word", data, '0);
    apb_read(soc_ctrl_start_addr + soc_scratch_offs, 1'b0, data);
    check_value("scratch kept", data, scratch_val);
    apb_read(soc_ctrl_start_addr + soc_boot_addr_offs, 1'b0, data);
    check_value("boot address kept", data, boot_val);
    apb_read(gpio_start_addr + gpio_oe_offs, 1'b0, data);
    check_value("gpio_oe kept", data, oe_val);
    apb_read(timer_start_addr + timer_cmp_offs, 1'b0, data);
    check_value("timer compare kept", data, n);

    end_run();
  end

endmodule

// File: vlog.f
periph_bus_pkg.sv
apb_node.sv
apb_gpio.sv
apb_timer.sv
apb_soc_ctrl.sv
periph_bus_wrap.sv
tb_periph_bus.sv
